// ==== common/isa_pkg.sv ====
package isa_pkg;

    localparam int INST_W = 32;

    typedef logic [INST_W-1:0] inst_t;

    // base opcodes, bits 6:0
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM  = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;

    // funct3 fields, bits 14:12
    localparam logic [2:0] F3_JALR      = 3'b000;
    localparam logic [2:0] F3_LOAD_RSVD = 3'b111;
    localparam logic [2:0] F3_ADDW      = 3'b000;
    localparam logic [2:0] F3_SLLW      = 3'b001;
    localparam logic [2:0] F3_SRLW      = 3'b101;

    // addi x0, x0, 0
    localparam inst_t NOP_INST = 32'h0000_0013;

    function automatic logic is_legal(inst_t inst);
        logic [6:0] opc;
        logic [2:0] f3;
        opc = inst[6:0];
        f3  = inst[14:12];
        case (opc)
            OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_BRANCH,
            OPC_OP_IMM, OPC_OP, OPC_MISC_MEM, OPC_SYSTEM: is_legal = 1'b1;
            OPC_JALR:  is_legal = (f3 == F3_JALR);
            OPC_LOAD:  is_legal = (f3 != F3_LOAD_RSVD);
            // only sb/sh/sw/sd exist
            OPC_STORE: is_legal = !inst[14];
            OPC_OP_IMM_32, OPC_OP_32:
                is_legal = (f3 == F3_ADDW) || (f3 == F3_SLLW) || (f3 == F3_SRLW);
            default:   is_legal = 1'b0;
        endcase
    endfunction

endpackage

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    localparam int ADDR_W = 64;

    typedef logic [ADDR_W-1:0] addr_t;

    // next-pc source from memory / writeback, codes 2 and 3 act as sequential
    typedef logic [1:0] pc_sel_t;
    localparam pc_sel_t SEL_SEQ    = 2'd0;
    localparam pc_sel_t SEL_BRANCH = 2'd1;

    localparam addr_t RESET_PC = '0;

    // direct mapped, one word per line
    localparam int CACHE_LINES = 8;
    localparam int INDEX_W     = $clog2(CACHE_LINES);
    localparam int TAG_W       = ADDR_W - 2 - INDEX_W;

    localparam int ROM_WORDS = 64;
    localparam int ROM_AW    = $clog2(ROM_WORDS);
    localparam int ROM_BYTES = ROM_WORDS * 4;

    localparam int REFILL_CYCLES = 3;
    localparam int REFILL_CNT_W  = $clog2(REFILL_CYCLES);

    localparam string ROM_IMAGE = "bench/prog.hex";

endpackage

// ==== logic/inst_rom.sv ====
module inst_rom
    import isa_pkg::*;
    import fetch_pkg::*;
(
    input  logic  CLK,
    input  addr_t rom_addr,
    input  logic  rom_rd,
    output inst_t rom_data
);

    inst_t mem [ROM_WORDS];

    logic [ROM_AW-1:0] word_addr;

    initial begin
        $readmemh(ROM_IMAGE, mem);
    end

    // word index, byte offset dropped
    assign word_addr = rom_addr[2 +: ROM_AW];

    // output holds between reads
    always_ff @(posedge CLK) begin
        if (rom_rd) begin
            rom_data <= mem[word_addr];
        end
    end

endmodule

// ==== logic/legal_check.sv ====
module legal_check
    import isa_pkg::*;
(
    input  logic  de_v,
    input  inst_t de_ir,
    input  logic  f_iam,
    input  logic  f_iaf,
    output logic  f_ii
);

    logic legal;
    logic fetch_fault;

    assign legal       = is_legal(de_ir);
    assign fetch_fault = f_iam || f_iaf;

    // address faults take precedence, the nop they carry is not decoded
    assign f_ii = de_v && !fetch_fault && !legal;

endmodule

// ==== fetch/inst_cache.sv ====
module inst_cache
    import isa_pkg::*;
    import fetch_pkg::*;
(
    input  logic  CLK,
    input  logic  reset,
    input  addr_t fetch_pc,
    input  logic  fetch_req,
    input  inst_t rom_data,
    output logic  cache_ready,
    output inst_t cache_word,
    output addr_t rom_addr,
    output logic  rom_rd
);

    logic [TAG_W-1:0]       tag_mem [CACHE_LINES];
    inst_t                  word_mem [CACHE_LINES];
    logic [CACHE_LINES-1:0] line_v;

    logic [INDEX_W-1:0]      idx;
    logic [TAG_W-1:0]        tag;
    logic                    hit;
    logic                    busy;
    logic                    start;
    logic                    fill;
    logic [REFILL_CNT_W-1:0] cnt;
    addr_t                   refill_pc;
    logic [INDEX_W-1:0]      refill_idx;
    logic [TAG_W-1:0]        refill_tag;

    assign idx = fetch_pc[2 +: INDEX_W];
    assign tag = fetch_pc[ADDR_W-1 -: TAG_W];
    assign hit = line_v[idx] && (tag_mem[idx] == tag);

    assign cache_ready = fetch_req && hit;
    assign cache_word  = word_mem[idx];

    assign refill_idx = refill_pc[2 +: INDEX_W];
    assign refill_tag = refill_pc[ADDR_W-1 -: TAG_W];
    assign rom_addr   = refill_pc;

    // new refill only when idle, a running one ignores fetch_pc
    assign start = !busy && fetch_req && !hit;
    assign fill  = busy && (cnt == REFILL_CNT_W'(REFILL_CYCLES - 1));

    always_ff @(posedge CLK) begin
        if (reset) begin
            busy   <= 1'b0;
            cnt    <= '0;
            rom_rd <= 1'b0;
            line_v <= '0;
        end else begin
            rom_rd <= start;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (fill) begin
                busy               <= 1'b0;
                line_v[refill_idx] <= 1'b1;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            refill_pc <= fetch_pc;
        end
    end

    // rom word has been stable since the second busy cycle
    always_ff @(posedge CLK) begin
        if (fill) begin
            tag_mem[refill_idx]  <= refill_tag;
            word_mem[refill_idx] <= rom_data;
        end
    end

endmodule

// ==== fetch/fetch_stage.sv ====
module fetch_stage
    import isa_pkg::*;
    import fetch_pkg::*;
(
    input  logic    CLK,
    input  logic    reset,
    input  pc_sel_t pc_mux,
    input  addr_t   br_target,
    input  addr_t   mtvec,
    input  logic    trap,
    input  logic    br_stall_de,
    input  logic    br_stall_agex,
    input  logic    br_stall_mem,
    input  logic    mem_stall,
    input  logic    cache_ready,
    input  inst_t   cache_word,
    output addr_t   fetch_pc,
    output logic    fetch_req,
    output logic    de_v,
    output inst_t   de_ir,
    output addr_t   de_npc,
    output logic    f_iam,
    output logic    f_iaf
);

    addr_t seq_pc;
    addr_t pc_next;
    logic  ld_pc;
    logic  v_next;
    logic  take_fault;
    logic  misaligned;
    logic  out_range;

    assign seq_pc     = fetch_pc + addr_t'(4);
    assign misaligned = |fetch_pc[1:0];
    assign out_range  = fetch_pc >= addr_t'(ROM_BYTES);

    // faulting pc never reaches the cache
    assign fetch_req = !(misaligned || out_range);

    // priority select of the next pc and the latch load
    // mem_stall gates the registers below
    always_comb begin
        pc_next    = seq_pc;
        ld_pc      = 1'b0;
        v_next     = 1'b0;
        take_fault = 1'b0;
        if (trap) begin
            pc_next = mtvec;
            ld_pc   = 1'b1;
        end else if (br_stall_mem && pc_mux == SEL_BRANCH) begin
            pc_next = br_target;
            ld_pc   = 1'b1;
        end else if (br_stall_de || br_stall_agex || br_stall_mem) begin
            // pc holds in the branch shadow
            ld_pc = 1'b0;
        end else if (!fetch_req) begin
            ld_pc      = 1'b1;
            v_next     = 1'b1;
            take_fault = 1'b1;
        end else if (cache_ready) begin
            ld_pc  = 1'b1;
            v_next = 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            fetch_pc <= RESET_PC;
            de_v     <= 1'b0;
            f_iam    <= 1'b0;
            f_iaf    <= 1'b0;
        end else if (!mem_stall) begin
            if (ld_pc) begin
                fetch_pc <= pc_next;
            end
            de_v  <= v_next;
            f_iam <= take_fault && misaligned;
            f_iaf <= take_fault && out_range;
        end
    end

    // latch payload only with a valid entry
    always_ff @(posedge CLK) begin
        if (!mem_stall && v_next) begin
            de_ir  <= take_fault ? NOP_INST : cache_word;
            de_npc <= seq_pc;
        end
    end

endmodule

// ==== logic/fetch_top.sv ====
module fetch_top
    import isa_pkg::*;
    import fetch_pkg::*;
(
    input  logic    CLK,
    input  logic    reset,
    input  pc_sel_t pc_mux,
    input  addr_t   br_target,
    input  addr_t   mtvec,
    input  logic    trap,
    input  logic    br_stall_de,
    input  logic    br_stall_agex,
    input  logic    br_stall_mem,
    input  logic    mem_stall,
    output logic    de_v,
    output inst_t   de_ir,
    output addr_t   de_npc,
    output logic    f_iam,
    output logic    f_iaf,
    output logic    f_ii
);

    addr_t fetch_pc;
    logic  fetch_req;
    logic  cache_ready;
    inst_t cache_word;
    addr_t rom_addr;
    logic  rom_rd;
    inst_t rom_data;

    fetch_stage u_fetch_stage (
        .CLK           (CLK),
        .reset         (reset),
        .pc_mux        (pc_mux),
        .br_target     (br_target),
        .mtvec         (mtvec),
        .trap          (trap),
        .br_stall_de   (br_stall_de),
        .br_stall_agex (br_stall_agex),
        .br_stall_mem  (br_stall_mem),
        .mem_stall     (mem_stall),
        .cache_ready   (cache_ready),
        .cache_word    (cache_word),
        .fetch_pc      (fetch_pc),
        .fetch_req     (fetch_req),
        .de_v          (de_v),
        .de_ir         (de_ir),
        .de_npc        (de_npc),
        .f_iam         (f_iam),
        .f_iaf         (f_iaf)
    );

    inst_cache u_inst_cache (
        .CLK         (CLK),
        .reset       (reset),
        .fetch_pc    (fetch_pc),
        .fetch_req   (fetch_req),
        .rom_data    (rom_data),
        .cache_ready (cache_ready),
        .cache_word  (cache_word),
        .rom_addr    (rom_addr),
        .rom_rd      (rom_rd)
    );

    inst_rom u_inst_rom (
        .CLK      (CLK),
        .rom_addr (rom_addr),
        .rom_rd   (rom_rd),
        .rom_data (rom_data)
    );

    legal_check u_legal_check (
        .de_v  (de_v),
        .de_ir (de_ir),
        .f_iam (f_iam),
        .f_iaf (f_iaf),
        .f_ii  (f_ii)
    );

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock (
    output logic CLK,
    output logic reset
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 5;

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    // released just after the fifth rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1 reset = 1'b0;
    end

endmodule

// ==== bench/fetch_sva.sv ====
module fetch_sva
    import isa_pkg::*;
    import fetch_pkg::*;
(
    input logic  CLK,
    input logic  reset,
    input logic  mem_stall,
    input logic  de_v,
    input inst_t de_ir,
    input addr_t de_npc,
    input logic  f_iam,
    input logic  f_iaf,
    input logic  f_ii
);

    int unsigned fail_count = 0;

    // latch comes out of reset empty
    a_reset_clears_v: assert property (@(posedge CLK) reset |=> !de_v)
        else begin
            fail_count++;
            $error("de_v high in the cycle after reset");
        end

    // whole decode latch freezes
    a_stall_holds: assert property (@(posedge CLK) disable iff (reset)
        mem_stall |=> $stable(de_v) && $stable(de_ir) && $stable(de_npc)
                      && $stable(f_iam) && $stable(f_iaf))
        else begin
            fail_count++;
            $error("decode outputs changed under mem_stall");
        end

    // faulting entry is a valid nop that is never decoded
    a_fault_entry: assert property (@(posedge CLK) disable iff (reset)
        (f_iam || f_iaf) |-> de_v && (de_ir == NOP_INST) && !f_ii)
        else begin
            fail_count++;
            $error("address fault without a valid nop entry");
        end

endmodule

bind fetch_top fetch_sva u_fetch_sva (
    .CLK       (CLK),
    .reset     (reset),
    .mem_stall (mem_stall),
    .de_v      (de_v),
    .de_ir     (de_ir),
    .de_npc    (de_npc),
    .f_iam     (f_iam),
    .f_iaf     (f_iaf),
    .f_ii      (f_ii)
);

// ==== bench/tb_fetch.sv ====
module tb_fetch
    import isa_pkg::*;
    import fetch_pkg::*;
();

    localparam int          DRIVE_DELAY   = 2;
    localparam int          NUM_ACTIONS   = 600;
    localparam int          ENTRY_TIMEOUT = 50;
    localparam int          RESET_TIMEOUT = 20;
    localparam logic [15:0] LFSR_SEED     = 16'd90;

    logic    CLK;
    logic    reset;
    pc_sel_t pc_mux;
    addr_t   br_target;
    addr_t   mtvec;
    logic    trap;
    logic    br_stall_de;
    logic    br_stall_agex;
    logic    br_stall_mem;
    logic    mem_stall;
    logic    de_v;
    inst_t   de_ir;
    addr_t   de_npc;
    logic    f_iam;
    logic    f_iaf;
    logic    f_ii;

    inst_t       image [ROM_WORDS];
    logic [15:0] lfsr;
    addr_t       model_pc;
    int          entries;

    tb_clock u_tb_clock (
        .CLK   (CLK),
        .reset (reset)
    );

    fetch_top u_fetch_top (
        .CLK           (CLK),
        .reset         (reset),
        .pc_mux        (pc_mux),
        .br_target     (br_target),
        .mtvec         (mtvec),
        .trap          (trap),
        .br_stall_de   (br_stall_de),
        .br_stall_agex (br_stall_agex),
        .br_stall_mem  (br_stall_mem),
        .mem_stall     (mem_stall),
        .de_v          (de_v),
        .de_ir         (de_ir),
        .de_npc        (de_npc),
        .f_iam         (f_iam),
        .f_iaf         (f_iaf),
        .f_ii          (f_ii)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic addr_t take_bits(int n);
        addr_t r;
        int    i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[ADDR_W-2:0], lfsr[0]};
        end
        return r;
    endfunction

    // mostly aligned rom addresses with some misaligned or past the rom
    function automatic addr_t pick_target();
        addr_t kind;
        addr_t base;
        kind = take_bits(3);
        base = take_bits(ROM_AW) << 2;
        if (kind == 0) begin
            return base + addr_t'(1) + (take_bits(1) << 1);
        end
        if (kind == 1) begin
            return base + addr_t'(ROM_BYTES);
        end
        return base;
    endfunction

    // legality straight from the encoding rules
    function automatic logic legal_by_rules(inst_t w);
        logic [6:0] opc;
        logic [2:0] f3;
        opc = w[6:0];
        f3  = w[14:12];
        if (opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_BRANCH, OPC_OP_IMM,
                        OPC_OP, OPC_MISC_MEM, OPC_SYSTEM}) begin
            return 1'b1;
        end
        if (opc == OPC_JALR) begin
            return f3 == 3'd0;
        end
        if (opc == OPC_LOAD) begin
            return f3 != 3'd7;
        end
        if (opc == OPC_STORE) begin
            return w[14] == 1'b0;
        end
        if (opc == OPC_OP_IMM_32 || opc == OPC_OP_32) begin
            return f3 inside {3'd0, 3'd1, 3'd5};
        end
        return 1'b0;
    endfunction

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_inst(string name, inst_t exp, inst_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic drive_idle();
        pc_mux        = SEL_SEQ;
        trap          = 1'b0;
        br_stall_de   = 1'b0;
        br_stall_agex = 1'b0;
        br_stall_mem  = 1'b0;
        mem_stall     = 1'b0;
    endtask

    // outputs are read and inputs changed just after each rising edge
    task automatic step_cycle();
        @(posedge CLK);
        #DRIVE_DELAY;
        if (u_fetch_top.u_fetch_sva.fail_count != 0) begin
            $display("a bound assertion failed before %0t", $time);
            abort_run();
        end
    endtask

    task automatic wait_reset_release();
        int waited;
        for (waited = 0; waited < RESET_TIMEOUT; waited++) begin
            @(posedge CLK);
            #DRIVE_DELAY;
            if (!reset) begin
                return;
            end
        end
        $display("reset still high after %0d cycles", RESET_TIMEOUT);
        abort_run();
    endtask

    // one decode entry against the image at the model pc
    task automatic check_entry();
        logic  bad_align;
        logic  bad_range;
        inst_t exp_ir;
        bad_align = |model_pc[1:0];
        bad_range = model_pc >= addr_t'(ROM_BYTES);
        if (bad_align || bad_range) begin
            exp_ir = NOP_INST;
        end else begin
            exp_ir = image[model_pc[2 +: ROM_AW]];
        end
        check_inst("de_ir", exp_ir, de_ir);
        check_addr("de_npc", model_pc + addr_t'(4), de_npc);
        check_flag("f_iam", bad_align, f_iam);
        check_flag("f_iaf", bad_range, f_iaf);
        check_flag("f_ii", !(bad_align || bad_range) && !legal_by_rules(exp_ir), f_ii);
        model_pc = model_pc + addr_t'(4);
        entries++;
    endtask

    task automatic wait_entry();
        int waited;
        drive_idle();
        for (waited = 0; waited < ENTRY_TIMEOUT; waited++) begin
            step_cycle();
            if (de_v) begin
                check_entry();
                return;
            end
        end
        $display("no valid entry within %0d cycles, model pc %h", ENTRY_TIMEOUT, model_pc);
        abort_run();
    endtask

    task automatic hold_stall();
        logic  snap_v;
        inst_t snap_ir;
        addr_t snap_npc;
        logic  snap_iam;
        logic  snap_iaf;
        logic  snap_ii;
        snap_v    = de_v;
        snap_ir   = de_ir;
        snap_npc  = de_npc;
        snap_iam  = f_iam;
        snap_iaf  = f_iaf;
        snap_ii   = f_ii;
        mem_stall = 1'b1;
        // a trap under mem_stall must not move the pc
        if (take_bits(1) == 1) begin
            trap  = 1'b1;
            mtvec = pick_target();
        end
        step_cycle();
        check_flag("de_v", snap_v, de_v);
        check_inst("de_ir", snap_ir, de_ir);
        check_addr("de_npc", snap_npc, de_npc);
        check_flag("f_iam", snap_iam, f_iam);
        check_flag("f_iaf", snap_iaf, f_iaf);
        check_flag("f_ii", snap_ii, f_ii);
        drive_idle();
    endtask

    task automatic branch_shadow();
        logic [1:0] which;
        which     = 2'(take_bits(2));
        br_target = pick_target();
        case (which)
            2'd0: begin
                br_stall_de = 1'b1;
                pc_mux      = pc_sel_t'(take_bits(2));
            end
            2'd1: begin
                br_stall_agex = 1'b1;
                pc_mux        = pc_sel_t'(take_bits(2));
            end
            2'd2: begin
                br_stall_mem = 1'b1;
                pc_mux       = SEL_SEQ;
            end
            default: begin
                // reserved select codes act as sequential
                br_stall_mem = 1'b1;
                pc_mux       = 2'd2 | pc_sel_t'(take_bits(1));
            end
        endcase
        step_cycle();
        check_flag("de_v", 1'b0, de_v);
        drive_idle();
    endtask

    task automatic redirect_branch();
        br_stall_mem = 1'b1;
        pc_mux       = SEL_BRANCH;
        br_target    = pick_target();
        step_cycle();
        check_flag("de_v", 1'b0, de_v);
        model_pc = br_target;
        drive_idle();
    endtask

    task automatic redirect_trap();
        trap  = 1'b1;
        mtvec = pick_target();
        step_cycle();
        check_flag("de_v", 1'b0, de_v);
        model_pc = mtvec;
        drive_idle();
    endtask

    initial begin
        int         n;
        logic [2:0] kind;
        drive_idle();
        br_target = RESET_PC;
        mtvec     = RESET_PC;
        lfsr      = LFSR_SEED;
        model_pc  = RESET_PC;
        entries   = 0;
        $readmemh(ROM_IMAGE, image);

        wait_reset_release();
        check_flag("de_v", 1'b0, de_v);
        check_flag("f_iam", 1'b0, f_iam);
        check_flag("f_iaf", 1'b0, f_iaf);
        check_flag("f_ii", 1'b0, f_ii);

        // first entry comes from the reset pc
        wait_entry();

        for (n = 0; n < NUM_ACTIONS; n++) begin
            kind = 3'(take_bits(3));
            case (kind)
                3'd3:    hold_stall();
                3'd4:    branch_shadow();
                3'd5:    redirect_branch();
                3'd6:    redirect_trap();
                default: wait_entry();
            endcase
        end

        if (u_fetch_top.u_fetch_sva.fail_count == 0) begin
            $display("%0d decode entries checked", entries);
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("bound assertions reported failures");
            abort_run();
        end
    end

endmodule

// ==== bench/prog.hex ====
// one 32-bit instruction word per line, hex, word address 0 to 63
// byte address of a word is its line number times 4
00100093
00200113
00208193
12345237
00000297
0080036f
000083e7
00000000
00208463
0000b503
00b13023
0000100f
00000073
0010059b
0010961b
0010d69b
002087bb
000090e7
00a00813
00b00893
0000f083
01100913
00014023
01200993
40208a33
0010a09b
00c0aab7
0000c0bb
00001b17
ffdffbef
ffffffff
00c00c13
00d00c93
00e00d13
0000007f
00f00d93
01000e13
0000000b
01100e93
01200f13
0000002f
01300f93
00108093
00110113
00118193
00120213
00128293
00130313
00138393
00140413
00148493
00150513
00158593
00160613
00168693
00170713
00178793
00180813
00188893
00190913
00198993
001a0a13
001a8a93
001b0b13

// ==== all.f ====
common/isa_pkg.sv
common/fetch_pkg.sv
logic/inst_rom.sv
logic/legal_check.sv
fetch/inst_cache.sv
fetch/fetch_stage.sv
logic/fetch_top.sv
bench/tb_clock.sv
bench/fetch_sva.sv
bench/tb_fetch.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
